// File: hdl/fp16_add_pkg.sv
`default_nettype none

package fp16_add_pkg;

    // ------------------------------------------------------------------
    // binary16 field widths
    // ------------------------------------------------------------------
    localparam int FLOAT_LEN = 16;
    localparam int EXP_LEN   = 5;
    localparam int MANT_LEN  = 10;

    // hidden bit + stored mantissa + five guard/round/sticky places
    localparam int ALIGN_LEN = MANT_LEN + 6;
    // one extra bit to catch the carry of the mantissa add
    localparam int SUM_LEN   = ALIGN_LEN + 1;
    // normalized value drops the hidden bit, keeps the five low places
    localparam int NORM_LEN  = MANT_LEN + 5;

    // ------------------------------------------------------------------
    // constants
    // ------------------------------------------------------------------
    // alignment shift never goes past the aligned width
    localparam int MAX_SHIFT = 15;
    // all-ones exponent, marks NaN and infinity
    localparam int EXP_MAX   = 31;

    // stages between the operand register and the stage 3 register
    localparam int SPECIAL_DELAY = 3;

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------
    typedef logic [FLOAT_LEN-1:0] fp16_t;
    typedef logic [EXP_LEN-1:0]   exp_t;
    typedef logic [MANT_LEN-1:0]  mant_t;
    typedef logic [ALIGN_LEN-1:0] align_t;
    typedef logic [SUM_LEN-1:0]   sum_t;
    typedef logic [NORM_LEN-1:0]  norm_t;

    // quiet NaN with sign clear and top mantissa bit set
    localparam fp16_t CANON_NAN = 16'h7E00;

endpackage

`default_nettype wire

// File: hdl/pipe_delay.sv
`default_nettype none

module pipe_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  wire      clk,
    input  wire      rst_n,
    input  payload_t din,
    output payload_t dout
);

    // stage 0 is loaded from din, the last stage drives dout
    payload_t stage_q [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign dout = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// File: hdl/fp16_align_add.sv
`default_nettype none

module fp16_align_add
    import fp16_add_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  fp16_t a_reg,
    input  fp16_t b_reg,
    output logic  sum_sign,
    output exp_t  sum_exp,
    output sum_t  sum_mant
);

    // operand fields
    logic  sign_a, sign_b;
    exp_t  exp_a, exp_b;
    mant_t mant_a, mant_b;

    // compare results and alignment
    logic               a_ge_b, b_ge_a;
    exp_t               exp_diff;
    logic [EXP_LEN-2:0] shift_amt;  // 4 bits hold the clamp of 15
    align_t             pre_a, pre_b;
    align_t             aligned_a, aligned_b;

    // stage 1 registers
    logic   sign_a_q, sign_b_q;
    exp_t   exp_a_q, exp_b_q;
    logic   sign_eq_q, a_ge_b_q, a_larger_q;
    align_t aligned_a_q, aligned_b_q;

    // ------------------------------------------------------------------
    // stage 1: compare, exponent difference, barrel shift
    // ------------------------------------------------------------------
    assign sign_a = a_reg[FLOAT_LEN-1];
    assign sign_b = b_reg[FLOAT_LEN-1];
    assign exp_a  = a_reg[FLOAT_LEN-2 -: EXP_LEN];
    assign exp_b  = b_reg[FLOAT_LEN-2 -: EXP_LEN];
    assign mant_a = a_reg[MANT_LEN-1:0];
    assign mant_b = b_reg[MANT_LEN-1:0];

    assign a_ge_b   = (exp_a >= exp_b);
    assign b_ge_a   = (exp_b >= exp_a);
    assign exp_diff = a_ge_b ? (exp_a - exp_b) : (exp_b - exp_a);
    assign shift_amt = (exp_diff > exp_t'(MAX_SHIFT)) ? (EXP_LEN-1)'(MAX_SHIFT)
                                                     : exp_diff[EXP_LEN-2:0];

    // hidden bit only for a nonzero exponent, subnormals use the raw difference
    assign pre_a = {(exp_a != '0), mant_a, {(ALIGN_LEN-MANT_LEN-1){1'b0}}};
    assign pre_b = {(exp_b != '0), mant_b, {(ALIGN_LEN-MANT_LEN-1){1'b0}}};

    // only the smaller operand moves; equal exponents leave both alone
    assign aligned_a = a_ge_b ? pre_a : (pre_a >> shift_amt);
    assign aligned_b = b_ge_a ? pre_b : (pre_b >> shift_amt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sign_a_q    <= 1'b0;
            sign_b_q    <= 1'b0;
            exp_a_q     <= '0;
            exp_b_q     <= '0;
            sign_eq_q   <= 1'b0;
            a_ge_b_q    <= 1'b0;
            a_larger_q  <= 1'b0;
            aligned_a_q <= '0;
            aligned_b_q <= '0;
        end else begin
            sign_a_q    <= sign_a;
            sign_b_q    <= sign_b;
            exp_a_q     <= exp_a;
            exp_b_q     <= exp_b;
            sign_eq_q   <= (sign_a == sign_b);
            a_ge_b_q    <= a_ge_b;
            a_larger_q  <= (aligned_a > aligned_b);
            aligned_a_q <= aligned_a;
            aligned_b_q <= aligned_b;
        end
    end

    // ------------------------------------------------------------------
    // stage 2: sign, larger exponent, add or subtract
    // ------------------------------------------------------------------
    // on a tie in magnitude b's sign wins, so exact cancellation keeps it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_sign <= 1'b0;
            sum_exp  <= '0;
            sum_mant <= '0;
        end else begin
            sum_sign <= (sign_eq_q || a_larger_q) ? sign_a_q : sign_b_q;
            sum_exp  <= a_ge_b_q ? exp_a_q : exp_b_q;
            if (sign_eq_q) begin
                sum_mant <= {1'b0, aligned_a_q} + {1'b0, aligned_b_q};
            end else if (a_larger_q) begin
                sum_mant <= {1'b0, aligned_a_q} - {1'b0, aligned_b_q};
            end else begin
                sum_mant <= {1'b0, aligned_b_q} - {1'b0, aligned_a_q};
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/fp16_normalize.sv
`default_nettype none

module fp16_normalize
    import fp16_add_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  exp_t  sum_exp,
    input  sum_t  sum_mant,
    output exp_t  norm_exp,
    output norm_t norm_mant
);

    // distance of the leading one below the hidden-bit place
    exp_t                      lead_zeros;
    logic                      lead_found;
    sum_t                      shifted;
    logic signed [EXP_LEN+1:0] exp_ext;
    logic signed [EXP_LEN+1:0] exp_adj;
    norm_t                     mant_next;
    exp_t                      exp_next;

    // ------------------------------------------------------------------
    // leading-one detect over bits 15..1
    // ------------------------------------------------------------------
    // a lone one in bit 0 counts as zero, as does an all-zero sum
    always_comb begin
        lead_zeros = '0;
        lead_found = 1'b0;
        for (int i = SUM_LEN - 2; i >= 1; i--) begin
            if (!lead_found && sum_mant[i]) begin
                lead_found = 1'b1;
                lead_zeros = exp_t'(SUM_LEN - 2 - i);
            end
        end
    end

    assign shifted = sum_mant << lead_zeros;
    assign exp_ext = {2'b00, sum_exp};

    // ------------------------------------------------------------------
    // mantissa shift and exponent adjust
    // ------------------------------------------------------------------
    always_comb begin
        if (sum_mant[SUM_LEN-1]) begin
            // carry out of the add, shift right by one
            mant_next = sum_mant[SUM_LEN-2:1];
            exp_adj   = exp_ext + 1;
        end else if (lead_found) begin
            // leading one drops off the top
            mant_next = shifted[NORM_LEN-1:0];
            exp_adj   = exp_ext - $signed({2'b00, lead_zeros});
        end else begin
            mant_next = '0;
            exp_adj   = '0;
        end
    end

    // clamp into 0..31, no subnormal output is formed
    always_comb begin
        if (exp_adj < 0) begin
            exp_next = '0;
        end else if (exp_adj > EXP_MAX) begin
            exp_next = exp_t'(EXP_MAX);
        end else begin
            exp_next = exp_adj[EXP_LEN-1:0];
        end
    end

    // stage 3 register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            norm_exp  <= '0;
            norm_mant <= '0;
        end else begin
            norm_exp  <= exp_next;
            norm_mant <= mant_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/fp16_normal_path.sv
`default_nettype none

module fp16_normal_path
    import fp16_add_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  fp16_t a_reg,
    input  fp16_t b_reg,
    output logic  norm_sign,
    output exp_t  norm_exp,
    output norm_t norm_mant
);

    // stage 2 results handed to the normalizer
    logic sum_sign;
    exp_t sum_exp;
    sum_t sum_mant;

    // stages 1 and 2: align, then add or subtract
    fp16_align_add u_align_add (
        .clk      (clk),
        .rst_n    (rst_n),
        .a_reg    (a_reg),
        .b_reg    (b_reg),
        .sum_sign (sum_sign),
        .sum_exp  (sum_exp),
        .sum_mant (sum_mant)
    );

    // stage 3: leading-one detect and exponent adjust
    fp16_normalize u_normalize (
        .clk       (clk),
        .rst_n     (rst_n),
        .sum_exp   (sum_exp),
        .sum_mant  (sum_mant),
        .norm_exp  (norm_exp),
        .norm_mant (norm_mant)
    );

    // sign takes no part in normalization, it just keeps pace
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            norm_sign <= 1'b0;
        end else begin
            norm_sign <= sum_sign;
        end
    end

endmodule

`default_nettype wire

// File: hdl/fp16_special_path.sv
`default_nettype none

module fp16_special_path
    import fp16_add_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  fp16_t a_reg,
    input  fp16_t b_reg,
    output logic  special_hit,
    output fp16_t special_word
);

    // classification of the registered operands
    logic  exp_max_a, exp_max_b;
    logic  is_nan_a, is_nan_b;
    logic  is_inf_a, is_inf_b;
    logic  hit;
    fp16_t word;

    assign exp_max_a = (a_reg[FLOAT_LEN-2 -: EXP_LEN] == exp_t'(EXP_MAX));
    assign exp_max_b = (b_reg[FLOAT_LEN-2 -: EXP_LEN] == exp_t'(EXP_MAX));

    assign is_nan_a = exp_max_a && (a_reg[MANT_LEN-1:0] != '0);
    assign is_nan_b = exp_max_b && (b_reg[MANT_LEN-1:0] != '0);
    assign is_inf_a = exp_max_a && (a_reg[MANT_LEN-1:0] == '0);
    assign is_inf_b = exp_max_b && (b_reg[MANT_LEN-1:0] == '0);

    // any all-ones exponent overrides the arithmetic result
    assign hit = exp_max_a || exp_max_b;

    // ------------------------------------------------------------------
    // special result selection
    // ------------------------------------------------------------------
    always_comb begin
        if (is_nan_a || is_nan_b) begin
            word = CANON_NAN;
        end else if (is_inf_a && is_inf_b && (a_reg[FLOAT_LEN-1] != b_reg[FLOAT_LEN-1])) begin
            // +inf plus -inf
            word = CANON_NAN;
        end else if (is_inf_a) begin
            word = a_reg;
        end else if (is_inf_b) begin
            word = b_reg;
        end else begin
            word = '0;
        end
    end

    // ------------------------------------------------------------------
    // delay to line up with the stage 3 register
    // ------------------------------------------------------------------
    pipe_delay #(
        .payload_t (logic),
        .DEPTH     (SPECIAL_DELAY)
    ) u_hit_delay (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (hit),
        .dout  (special_hit)
    );

    pipe_delay #(
        .payload_t (fp16_t),
        .DEPTH     (SPECIAL_DELAY)
    ) u_word_delay (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (word),
        .dout  (special_word)
    );

endmodule

`default_nettype wire

// File: hdl/fp16_round_select.sv
`default_nettype none

module fp16_round_select
    import fp16_add_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  logic  norm_sign,
    input  exp_t  norm_exp,
    input  norm_t norm_mant,
    input  logic  special_hit,
    input  fp16_t special_word,
    output fp16_t result
);

    // kept mantissa and the bits below it
    mant_t              mant_main;
    logic               lsb, guard_bit, round_bit, sticky_bit;
    logic               round_up;
    logic [MANT_LEN:0]  mant_round;
    logic [EXP_LEN:0]   exp_tmp;
    exp_t               exp_final;
    mant_t              mant_final;
    fp16_t              normal_word;

    // ------------------------------------------------------------------
    // round to nearest, ties to even
    // ------------------------------------------------------------------
    assign mant_main  = norm_mant[NORM_LEN-1 -: MANT_LEN];
    assign lsb        = norm_mant[NORM_LEN-MANT_LEN];
    assign guard_bit  = norm_mant[NORM_LEN-MANT_LEN-1];
    assign round_bit  = norm_mant[NORM_LEN-MANT_LEN-2];
    // sticky folds the lowest three places
    assign sticky_bit = |norm_mant[NORM_LEN-MANT_LEN-3:0];

    // above half, or exactly half with an odd lsb
    assign round_up = (guard_bit && round_bit)
                   || (guard_bit && !round_bit && sticky_bit)
                   || (lsb && guard_bit && !round_bit && !sticky_bit);

    assign mant_round = {1'b0, mant_main} + (MANT_LEN+1)'(round_up);

    // carry out of the mantissa bumps the exponent
    assign exp_tmp    = mant_round[MANT_LEN] ? ({1'b0, norm_exp} + 1'b1) : {1'b0, norm_exp};
    assign exp_final  = (exp_tmp > EXP_MAX) ? exp_t'(EXP_MAX) : exp_tmp[EXP_LEN-1:0];
    assign mant_final = mant_round[MANT_LEN] ? mant_round[MANT_LEN:1]
                                             : mant_round[MANT_LEN-1:0];

    assign normal_word = {norm_sign, exp_final, mant_final};

    // ------------------------------------------------------------------
    // output register
    // ------------------------------------------------------------------
    // NaN or infinity replaces whatever the arithmetic path produced
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result <= special_hit ? special_word : normal_word;
        end
    end

endmodule

`default_nettype wire

// File: hdl/fp16_add.sv
`default_nettype none

module fp16_add
    import fp16_add_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  fp16_t a,
    input  fp16_t b,
    output fp16_t result
);

    // operand register, the start of the five cycle pipeline
    fp16_t a_reg;
    fp16_t b_reg;

    // stage 3 outputs of the arithmetic path
    logic  norm_sign;
    exp_t  norm_exp;
    norm_t norm_mant;

    // special result, delayed to meet stage 3
    logic  special_hit;
    fp16_t special_word;

    // ------------------------------------------------------------------
    // operand capture
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_reg <= '0;
            b_reg <= '0;
        end else begin
            a_reg <= a;
            b_reg <= b;
        end
    end

    // ------------------------------------------------------------------
    // two paths in parallel on the registered operands
    // ------------------------------------------------------------------
    fp16_normal_path u_normal_path (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_reg     (a_reg),
        .b_reg     (b_reg),
        .norm_sign (norm_sign),
        .norm_exp  (norm_exp),
        .norm_mant (norm_mant)
    );

    fp16_special_path u_special_path (
        .clk          (clk),
        .rst_n        (rst_n),
        .a_reg        (a_reg),
        .b_reg        (b_reg),
        .special_hit  (special_hit),
        .special_word (special_word)
    );

    // rounding, selection and output register
    fp16_round_select u_round_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .norm_sign    (norm_sign),
        .norm_exp     (norm_exp),
        .norm_mant    (norm_mant),
        .special_hit  (special_hit),
        .special_word (special_word),
        .result       (result)
    );

endmodule

`default_nettype wire

// File: test/fp16_add_model.svh
`ifndef FP16_ADD_MODEL_SVH
`define FP16_ADD_MODEL_SVH

`default_nettype none

// ----------------------------------------------------------------------
// reference sum of two binary16 words, integer arithmetic throughout
// ----------------------------------------------------------------------
function automatic logic [15:0] expected_sum(input logic [15:0] op_a, input logic [15:0] op_b);
    int   sa, sb, ea, eb, ma, mb;
    int   fa, fb, shift, exp_big;
    int   sum, sign, exp_n, norm, lead;
    int   kept, guard_b, round_b, sticky_b, up;
    logic nan_a, nan_b, inf_a, inf_b;

    sa = op_a[15];
    sb = op_b[15];
    ea = op_a[14:10];
    eb = op_b[14:10];
    ma = op_a[9:0];
    mb = op_b[9:0];

    // an all-ones exponent on either side decides the result alone
    if (ea == fp16_add_pkg::EXP_MAX || eb == fp16_add_pkg::EXP_MAX) begin
        nan_a = (ea == fp16_add_pkg::EXP_MAX) && (ma != 0);
        nan_b = (eb == fp16_add_pkg::EXP_MAX) && (mb != 0);
        inf_a = (ea == fp16_add_pkg::EXP_MAX) && (ma == 0);
        inf_b = (eb == fp16_add_pkg::EXP_MAX) && (mb == 0);
        if (nan_a || nan_b)
            return fp16_add_pkg::CANON_NAN;
        if (inf_a && inf_b && (sa != sb))
            return fp16_add_pkg::CANON_NAN;
        if (inf_a)
            return op_a;
        return op_b;
    end

    // hidden bit only for a nonzero exponent, five empty places below
    fa = (((ea != 0) ? 1024 : 0) + ma) * 32;
    fb = (((eb != 0) ? 1024 : 0) + mb) * 32;

    // the smaller operand moves right by the raw difference, at most 15
    shift = (ea >= eb) ? (ea - eb) : (eb - ea);
    if (shift > fp16_add_pkg::MAX_SHIFT)
        shift = fp16_add_pkg::MAX_SHIFT;
    if (ea < eb)
        fa = fa >> shift;
    if (eb < ea)
        fb = fb >> shift;
    exp_big = (ea >= eb) ? ea : eb;

    // equal magnitudes of opposite sign keep b's sign
    if (sa == sb) begin
        sum  = fa + fb;
        sign = sa;
    end else if (fa > fb) begin
        sum  = fa - fb;
        sign = sa;
    end else begin
        sum  = fb - fa;
        sign = sb;
    end

    // normalize so the leading one falls just above the kept bits
    if (sum >= 65536) begin
        norm  = (sum >> 1) % 32768;
        exp_n = exp_big + 1;
    end else if (sum >= 2) begin
        lead = 15;
        while (((sum >> lead) & 1) == 0)
            lead--;
        norm  = (sum << (15 - lead)) % 32768;
        exp_n = exp_big - (15 - lead);
    end else begin
        norm  = 0;
        exp_n = 0;
    end
    if (exp_n < 0)
        exp_n = 0;
    if (exp_n > fp16_add_pkg::EXP_MAX)
        exp_n = fp16_add_pkg::EXP_MAX;

    // nearest, ties to even
    kept     = norm >> 5;
    guard_b  = (norm >> 4) & 1;
    round_b  = (norm >> 3) & 1;
    sticky_b = ((norm % 8) != 0) ? 1 : 0;
    up       = (guard_b == 1) && (round_b == 1 || sticky_b == 1 || (kept % 2) == 1);
    kept     = kept + up;

    // mantissa overflow shifts right and bumps the exponent
    if (kept == 1024) begin
        kept  = kept >> 1;
        exp_n = exp_n + 1;
        if (exp_n > fp16_add_pkg::EXP_MAX)
            exp_n = fp16_add_pkg::EXP_MAX;
    end

    return {sign[0], exp_n[4:0], kept[9:0]};
endfunction

`default_nettype wire

`endif

// File: test/tb_fp16_add.sv
`include "fp16_add_model.svh"

`default_nettype none

module tb_fp16_add
    import fp16_add_pkg::*;
();

    localparam int LATENCY      = 5;
    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_PAIRS = 500;
    localparam int WAIT_LIMIT   = 40;

    logic  clk;
    logic  rst_n;
    fp16_t a;
    fp16_t b;
    fp16_t result;

    // expected words in flight, oldest first, with the cycle they are due
    fp16_t       exp_q  [$];
    string       name_q [$];
    int unsigned due_q  [$];

    int unsigned cycle_count;
    integer      seed;
    int          check_count, error_count;
    int          test_checks, test_errors;
    string       test_name;

    fp16_add UUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .a      (a),
        .b      (b),
        .result (result)
    );

    always #10 clk = ~clk;

    // rising edges since time zero
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input fp16_t expected, input fp16_t actual);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        $display("test %-10s %0d checks, %0d mismatches", test_name, test_checks, test_errors);
    endtask

    // one pair per call, driven just after the rising edge
    task automatic send_pair(input fp16_t op_a, input fp16_t op_b);
        @(posedge clk);
        #1;
        a = op_a;
        b = op_b;
        exp_q.push_back(expected_sum(op_a, op_b));
        name_q.push_back(test_name);
        due_q.push_back(cycle_count + LATENCY);
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT)
                stop_on_timeout("the pipeline to drain");
        end
    endtask

    // result must stay zero while reset is held, even with live operands
    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            check_value("reset", '0, result);
            waited++;
            if (waited > WAIT_LIMIT)
                stop_on_timeout("reset release");
        end
    endtask

    // compare at the falling edge, away from the register update
    always @(negedge clk) begin
        if (due_q.size() != 0 && due_q[0] == cycle_count) begin
            check_value(name_q.pop_front(), exp_q.pop_front(), result);
            void'(due_q.pop_front());
        end
    end

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin : main
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;

        clk         = 1'b0;
        rst_n       = 1'b0;
        // 1.0 + 1.0 sits on the inputs, a live pipeline would show 2.0
        a           = 16'h3C00;
        b           = 16'h3C00;
        cycle_count = 0;
        seed        = 32'he1fb_cb78;
        check_count = 0;
        error_count = 0;

        // first capture after release lands on result only five edges later
        start_test("reset");
        wait_reset_release();
        repeat (3) begin
            @(negedge clk);
            check_value("reset", '0, result);
        end
        finish_test();

        // carries, ties on even and odd lsb, shift clamp, subnormals
        start_test("same_sign");
        send_pair(16'h3C00, 16'h3C00);
        send_pair(16'h3E00, 16'h3E00);
        send_pair(16'h3C01, 16'h3C00);
        send_pair(16'h3C03, 16'h3C00);
        send_pair(16'h3C00, 16'h1000);
        send_pair(16'h3C01, 16'h1000);
        send_pair(16'h5800, 16'h1000);
        send_pair(16'h1000, 16'h6BFF);
        send_pair(16'h0001, 16'h0001);
        send_pair(16'h7BFF, 16'h7BFF);
        send_pair(16'hBC00, 16'hBC00);
        drain_results();
        finish_test();

        // exact cancellation keeps b's sign
        start_test("opp_sign");
        send_pair(16'h3C00, 16'hBC00);
        send_pair(16'hBC00, 16'h3C00);
        send_pair(16'h4000, 16'hBC00);
        send_pair(16'h3C00, 16'hC000);
        send_pair(16'h3C01, 16'hBC00);
        send_pair(16'h5800, 16'h9000);
        send_pair(16'h0200, 16'h8100);
        drain_results();
        finish_test();

        start_test("special");
        send_pair(16'h7E00, 16'h3C00);
        send_pair(16'h3C00, 16'h7C01);
        send_pair(16'h7C00, 16'hFC00);
        send_pair(16'h7C00, 16'h7C00);
        send_pair(16'hFC00, 16'h0000);
        send_pair(16'h7C00, 16'h3C00);
        send_pair(16'h3C00, 16'hFC00);
        send_pair(16'hFC00, 16'hC500);
        drain_results();
        finish_test();

        // back to back, one pair per cycle
        start_test("random");
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            send_pair(rnd_a[15:0], rnd_b[15:0]);
        end
        drain_results();
        finish_test();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fp16_add.f
+incdir+test
hdl/fp16_add_pkg.sv
hdl/pipe_delay.sv
hdl/fp16_align_add.sv
hdl/fp16_normalize.sv
hdl/fp16_normal_path.sv
hdl/fp16_special_path.sv
hdl/fp16_round_select.sv
hdl/fp16_add.sv
test/tb_fp16_add.sv

// File: Bender.yml
package:
  name: fp16_add

sources:
  - hdl/fp16_add_pkg.sv
  - hdl/pipe_delay.sv
  - hdl/fp16_align_add.sv
  - hdl/fp16_normalize.sv
  - hdl/fp16_normal_path.sv
  - hdl/fp16_special_path.sv
  - hdl/fp16_round_select.sv
  - hdl/fp16_add.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_fp16_add.sv
